// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

  // Physical register tag
  localparam int RNID_W = 6;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // Access size, straight from funct3[1:0]
  typedef enum logic [1:0] {
    SIZE_B  = 2'b00,
    SIZE_H  = 2'b01,
    SIZE_W  = 2'b10,
    SIZE_DW = 2'b11
  } size_t;

  // ------------------------------
  // Instruction formats
  // ------------------------------

  // I-type, used by loads
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // S-type, used by stores
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // Opcode and funct3 sit at the same bits in both views
  typedef union packed {
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
  } inst_u;

endpackage

// ==== hdl/lsu_issue_select.sv ====
`timescale 1ns/1ns

module lsu_issue_select
  import lsu_pkg::*;
#(
  parameter int XLEN_W = 64
) (
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  logic              i_rs_valid,
  input  inst_u             i_rs_inst,
  input  logic [RNID_W-1:0] i_rs_rnid,
  input  logic [XLEN_W-1:0] i_rs_rs1_data,
  input  logic [XLEN_W-1:0] i_rs_rs2_data,

  input  logic              i_rp_valid,
  input  inst_u             i_rp_inst,
  input  logic [RNID_W-1:0] i_rp_rnid,
  input  logic [XLEN_W-1:0] i_rp_rs1_data,
  input  logic [XLEN_W-1:0] i_rp_rs2_data,

  output logic              o_ex0_valid,
  output inst_u             o_ex0_inst,
  output logic [RNID_W-1:0] o_ex0_rnid,
  output logic [XLEN_W-1:0] o_ex0_rs1_data,
  output logic [XLEN_W-1:0] o_ex0_rs2_data,
  output logic              o_ex0_rs_conflicted
);

  logic              r_rs_valid;
  inst_u             r_rs_inst;
  logic [RNID_W-1:0] r_rs_rnid;
  logic [XLEN_W-1:0] r_rs_rs1_data;
  logic [XLEN_W-1:0] r_rs_rs2_data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rs_valid <= 1'b0;
    end else begin
      r_rs_valid <= i_rs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rs_inst     <= i_rs_inst;
    r_rs_rnid     <= i_rs_rnid;
    r_rs_rs1_data <= i_rs_rs1_data;
    r_rs_rs2_data <= i_rs_rs2_data;
  end

  // Replay wins the slot
  assign o_ex0_valid    = i_rp_valid | r_rs_valid;
  assign o_ex0_inst     = i_rp_valid ? i_rp_inst     : r_rs_inst;
  assign o_ex0_rnid     = i_rp_valid ? i_rp_rnid     : r_rs_rnid;
  assign o_ex0_rs1_data = i_rp_valid ? i_rp_rs1_data : r_rs_rs1_data;
  assign o_ex0_rs2_data = i_rp_valid ? i_rp_rs2_data : r_rs_rs2_data;

  assign o_ex0_rs_conflicted = i_rp_valid & r_rs_valid;  // rs entry dropped

endmodule

// ==== hdl/lsu_addr_gen.sv ====
`timescale 1ns/1ns

module lsu_addr_gen
  import lsu_pkg::*;
#(
  parameter int XLEN_W = 64,
  parameter int LINE_B = 16
) (
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  logic              i_ex0_valid,
  input  inst_u             i_ex0_inst,
  input  logic [RNID_W-1:0] i_ex0_rnid,
  input  logic [XLEN_W-1:0] i_ex0_rs1_data,
  input  logic [XLEN_W-1:0] i_ex0_rs2_data,

  output logic              o_l1d_rd_valid,
  output logic [XLEN_W-1:0] o_l1d_rd_paddr,

  output logic              o_st_valid,
  output logic [XLEN_W-1:0] o_st_paddr,
  output logic [XLEN_W-1:0] o_st_data,
  output size_t             o_st_size,

  output logic              o_ex1_valid,
  output logic [XLEN_W-1:0] o_ex1_paddr,
  output size_t             o_ex1_size,
  output logic              o_ex1_sign,
  output logic [4:0]        o_ex1_rd_idx,
  output logic [RNID_W-1:0] o_ex1_rnid
);

  localparam int LINE_OFS_W = $clog2(LINE_B);

  logic              r_valid;
  inst_u             r_inst;
  logic [RNID_W-1:0] r_rnid;
  logic [XLEN_W-1:0] r_rs1_data;
  logic [XLEN_W-1:0] r_rs2_data;

  logic              w_is_load;
  logic              w_is_store;
  logic [11:0]       w_imm;
  logic [XLEN_W-1:0] w_eaddr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_ex0_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_inst     <= i_ex0_inst;
    r_rnid     <= i_ex0_rnid;
    r_rs1_data <= i_ex0_rs1_data;
    r_rs2_data <= i_ex0_rs2_data;
  end

  // ------------------------------
  // Decode and address
  // ------------------------------
  assign w_is_load  = r_valid & (r_inst.i_fmt.opcode == OPC_LOAD);
  assign w_is_store = r_valid & (r_inst.s_fmt.opcode == OPC_STORE);

  assign w_imm = w_is_store ? {r_inst.s_fmt.imm_hi, r_inst.s_fmt.imm_lo} : r_inst.i_fmt.imm;
  assign w_eaddr = r_rs1_data + {{(XLEN_W-12){w_imm[11]}}, w_imm};

  // Line-aligned cache read
  assign o_l1d_rd_valid = w_is_load;
  assign o_l1d_rd_paddr = {w_eaddr[XLEN_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};

  assign o_st_valid = w_is_store;
  assign o_st_paddr = w_eaddr;
  assign o_st_data  = r_rs2_data;  // stored unaltered
  assign o_st_size  = size_t'(r_inst.s_fmt.funct3[1:0]);

  // Only loads go on to EX2
  assign o_ex1_valid  = w_is_load;
  assign o_ex1_paddr  = w_eaddr;
  assign o_ex1_size   = size_t'(r_inst.i_fmt.funct3[1:0]);
  assign o_ex1_sign   = ~r_inst.i_fmt.funct3[2];
  assign o_ex1_rd_idx = r_inst.i_fmt.rd;
  assign o_ex1_rnid   = r_rnid;

endmodule

// ==== hdl/lsu_load_align.sv ====
`timescale 1ns/1ns

module lsu_load_align
  import lsu_pkg::*;
#(
  parameter int XLEN_W = 64,
  parameter int LINE_B = 16
) (
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_ex1_valid,
  input  logic [XLEN_W-1:0]   i_ex1_paddr,
  input  size_t               i_ex1_size,
  input  logic                i_ex1_sign,
  input  logic [4:0]          i_ex1_rd_idx,
  input  logic [RNID_W-1:0]   i_ex1_rnid,

  input  logic                i_l1d_hit,
  input  logic [LINE_B*8-1:0] i_l1d_line,
  input  logic [XLEN_W/8-1:0] i_fwd_dw,
  input  logic [XLEN_W-1:0]   i_fwd_data,

  output logic                o_ex2_miss,
  output logic                o_ex2_valid,
  output logic [XLEN_W-1:0]   o_ex2_data,
  output logic [4:0]          o_ex2_rd_idx,
  output logic [RNID_W-1:0]   o_ex2_rnid
);

  localparam int DW_B       = XLEN_W / 8;
  localparam int DW_OFS_W   = $clog2(DW_B);
  localparam int LINE_OFS_W = $clog2(LINE_B);

  logic                  r_valid;
  logic [LINE_OFS_W-1:0] r_ofs;
  size_t                 r_size;
  logic                  r_sign;
  logic [4:0]            r_rd_idx;
  logic [RNID_W-1:0]     r_rnid;

  logic [XLEN_W-1:0]     w_l1d_word;
  logic [DW_B-1:0]       w_size_mask;
  logic [DW_OFS_W-1:0]   w_align;
  logic [DW_OFS_W-1:0]   w_ofs;
  logic [DW_B-1:0]       w_need_dw;
  logic [DW_B-1:0]       w_fwd_dw_sh;
  logic [XLEN_W-1:0]     w_fwd_data_sh;
  logic [XLEN_W-1:0]     w_l1d_sh;
  logic [XLEN_W-1:0]     w_merged;
  logic [XLEN_W-1:0]     w_bit_mask;
  logic                  w_sign_bit;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_ex1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ofs    <= i_ex1_paddr[LINE_OFS_W-1:0];
    r_size   <= i_ex1_size;
    r_sign   <= i_ex1_sign;
    r_rd_idx <= i_ex1_rd_idx;
    r_rnid   <= i_ex1_rnid;
  end

  // Word at the doubleword offset inside the line
  assign w_l1d_word = i_l1d_line[r_ofs[LINE_OFS_W-1:DW_OFS_W]*XLEN_W +: XLEN_W];

  always_comb begin
    case (r_size)
      SIZE_B: begin
        w_size_mask = DW_B'(8'h01);
        w_align     = DW_OFS_W'(0);
      end
      SIZE_H: begin
        w_size_mask = DW_B'(8'h03);
        w_align     = DW_OFS_W'(1);
      end
      SIZE_W: begin
        w_size_mask = DW_B'(8'h0f);
        w_align     = DW_OFS_W'(3);
      end
      default: begin
        w_size_mask = {DW_B{XLEN_W == 64}};  // no DW access on RV32
        w_align     = DW_OFS_W'(7);
      end
    endcase
  end

  assign w_ofs = r_ofs[DW_OFS_W-1:0] & ~w_align;  // rounded down to size

  // ------------------------------
  // Align and merge
  // ------------------------------
  assign w_need_dw     = w_size_mask << w_ofs;
  assign w_fwd_dw_sh   = i_fwd_dw >> w_ofs;
  assign w_fwd_data_sh = i_fwd_data >> {w_ofs, 3'b000};
  assign w_l1d_sh      = w_l1d_word >> {w_ofs, 3'b000};

  for (genvar b = 0; b < DW_B; b++) begin : g_byte
    assign w_merged[b*8 +: 8]   = w_fwd_dw_sh[b] ? w_fwd_data_sh[b*8 +: 8] : w_l1d_sh[b*8 +: 8];
    assign w_bit_mask[b*8 +: 8] = {8{w_size_mask[b]}};
  end

  always_comb begin
    case (r_size)
      SIZE_B:  w_sign_bit = w_merged[7];
      SIZE_H:  w_sign_bit = w_merged[15];
      SIZE_W:  w_sign_bit = w_merged[31];
      default: w_sign_bit = 1'b0;
    endcase
  end

  // Truncate, then fill upper bytes with the sign
  assign o_ex2_data = (w_merged & w_bit_mask) | (~w_bit_mask & {XLEN_W{r_sign & w_sign_bit}});

  assign o_ex2_miss   = r_valid & ~i_l1d_hit & ((i_fwd_dw & w_need_dw) != w_need_dw);
  assign o_ex2_valid  = r_valid;
  assign o_ex2_rd_idx = r_rd_idx;
  assign o_ex2_rnid   = r_rnid;

endmodule

// ==== hdl/lsu_writeback.sv ====
`timescale 1ns/1ns

module lsu_writeback
  import lsu_pkg::*;
#(
  parameter int XLEN_W = 64
) (
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  logic              i_ex2_valid,
  input  logic              i_ex2_miss,
  input  logic [XLEN_W-1:0] i_ex2_data,
  input  logic [4:0]        i_ex2_rd_idx,
  input  logic [RNID_W-1:0] i_ex2_rnid,

  output logic              o_wr_valid,
  output logic [RNID_W-1:0] o_wr_rnid,
  output logic [XLEN_W-1:0] o_wr_data
);

  logic              r_valid;
  logic              r_miss;
  logic [4:0]        r_rd_idx;
  logic [RNID_W-1:0] r_rnid;
  logic [XLEN_W-1:0] r_data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
      r_miss  <= 1'b0;
    end else begin
      r_valid <= i_ex2_valid;
      r_miss  <= i_ex2_miss;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rd_idx <= i_ex2_rd_idx;
    r_rnid   <= i_ex2_rnid;
    r_data   <= i_ex2_data;
  end

  assign o_wr_valid = r_valid & ~r_miss & (r_rd_idx != 5'd0);  // x0 never written
  assign o_wr_rnid  = r_rnid;
  assign o_wr_data  = r_data;

endmodule

// ==== hdl/lsu_pipe.sv ====
`timescale 1ns/1ns

module lsu_pipe
  import lsu_pkg::*;
#(
  parameter int XLEN_W = 64,
  parameter int LINE_B = 16
) (
  input  logic                i_clk,
  input  logic                i_reset_n,

  // Reservation station issue
  input  logic                i_rs_valid,
  input  inst_u               i_rs_inst,
  input  logic [RNID_W-1:0]   i_rs_rnid,
  input  logic [XLEN_W-1:0]   i_rs_rs1_data,
  input  logic [XLEN_W-1:0]   i_rs_rs2_data,

  // Memory queue replay
  input  logic                i_rp_valid,
  input  inst_u               i_rp_inst,
  input  logic [RNID_W-1:0]   i_rp_rnid,
  input  logic [XLEN_W-1:0]   i_rp_rs1_data,
  input  logic [XLEN_W-1:0]   i_rp_rs2_data,

  output logic                o_ex0_rs_conflicted,

  // L1D read
  output logic                o_l1d_rd_valid,
  output logic [XLEN_W-1:0]   o_l1d_rd_paddr,
  input  logic                i_l1d_hit,
  input  logic [LINE_B*8-1:0] i_l1d_line,

  // Store-buffer forward
  input  logic [XLEN_W/8-1:0] i_fwd_dw,
  input  logic [XLEN_W-1:0]   i_fwd_data,

  // Store report
  output logic                o_st_valid,
  output logic [XLEN_W-1:0]   o_st_paddr,
  output logic [XLEN_W-1:0]   o_st_data,
  output size_t               o_st_size,

  output logic                o_ex2_miss,

  // Register file write
  output logic                o_wr_valid,
  output logic [RNID_W-1:0]   o_wr_rnid,
  output logic [XLEN_W-1:0]   o_wr_data
);

  // ------------------------------
  // Stage wires
  // ------------------------------
  logic              w_ex0_valid;
  inst_u             w_ex0_inst;
  logic [RNID_W-1:0] w_ex0_rnid;
  logic [XLEN_W-1:0] w_ex0_rs1_data;
  logic [XLEN_W-1:0] w_ex0_rs2_data;

  logic              w_ex1_valid;
  logic [XLEN_W-1:0] w_ex1_paddr;
  size_t             w_ex1_size;
  logic              w_ex1_sign;
  logic [4:0]        w_ex1_rd_idx;
  logic [RNID_W-1:0] w_ex1_rnid;

  logic              w_ex2_valid;
  logic [XLEN_W-1:0] w_ex2_data;
  logic [4:0]        w_ex2_rd_idx;
  logic [RNID_W-1:0] w_ex2_rnid;

  lsu_issue_select #(
    .XLEN_W (XLEN_W)
  ) u_issue_select (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_rs_valid          (i_rs_valid),
    .i_rs_inst           (i_rs_inst),
    .i_rs_rnid           (i_rs_rnid),
    .i_rs_rs1_data       (i_rs_rs1_data),
    .i_rs_rs2_data       (i_rs_rs2_data),
    .i_rp_valid          (i_rp_valid),
    .i_rp_inst           (i_rp_inst),
    .i_rp_rnid           (i_rp_rnid),
    .i_rp_rs1_data       (i_rp_rs1_data),
    .i_rp_rs2_data       (i_rp_rs2_data),
    .o_ex0_valid         (w_ex0_valid),
    .o_ex0_inst          (w_ex0_inst),
    .o_ex0_rnid          (w_ex0_rnid),
    .o_ex0_rs1_data      (w_ex0_rs1_data),
    .o_ex0_rs2_data      (w_ex0_rs2_data),
    .o_ex0_rs_conflicted (o_ex0_rs_conflicted)
  );

  lsu_addr_gen #(
    .XLEN_W (XLEN_W),
    .LINE_B (LINE_B)
  ) u_addr_gen (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex0_valid    (w_ex0_valid),
    .i_ex0_inst     (w_ex0_inst),
    .i_ex0_rnid     (w_ex0_rnid),
    .i_ex0_rs1_data (w_ex0_rs1_data),
    .i_ex0_rs2_data (w_ex0_rs2_data),
    .o_l1d_rd_valid (o_l1d_rd_valid),
    .o_l1d_rd_paddr (o_l1d_rd_paddr),
    .o_st_valid     (o_st_valid),
    .o_st_paddr     (o_st_paddr),
    .o_st_data      (o_st_data),
    .o_st_size      (o_st_size),
    .o_ex1_valid    (w_ex1_valid),
    .o_ex1_paddr    (w_ex1_paddr),
    .o_ex1_size     (w_ex1_size),
    .o_ex1_sign     (w_ex1_sign),
    .o_ex1_rd_idx   (w_ex1_rd_idx),
    .o_ex1_rnid     (w_ex1_rnid)
  );

  lsu_load_align #(
    .XLEN_W (XLEN_W),
    .LINE_B (LINE_B)
  ) u_load_align (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_ex1_valid  (w_ex1_valid),
    .i_ex1_paddr  (w_ex1_paddr),
    .i_ex1_size   (w_ex1_size),
    .i_ex1_sign   (w_ex1_sign),
    .i_ex1_rd_idx (w_ex1_rd_idx),
    .i_ex1_rnid   (w_ex1_rnid),
    .i_l1d_hit    (i_l1d_hit),
    .i_l1d_line   (i_l1d_line),
    .i_fwd_dw     (i_fwd_dw),
    .i_fwd_data   (i_fwd_data),
    .o_ex2_miss   (o_ex2_miss),
    .o_ex2_valid  (w_ex2_valid),
    .o_ex2_data   (w_ex2_data),
    .o_ex2_rd_idx (w_ex2_rd_idx),
    .o_ex2_rnid   (w_ex2_rnid)
  );

  lsu_writeback #(
    .XLEN_W (XLEN_W)
  ) u_writeback (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_ex2_valid  (w_ex2_valid),
    .i_ex2_miss   (o_ex2_miss),
    .i_ex2_data   (w_ex2_data),
    .i_ex2_rd_idx (w_ex2_rd_idx),
    .i_ex2_rnid   (w_ex2_rnid),
    .o_wr_valid   (o_wr_valid),
    .o_wr_rnid    (o_wr_rnid),
    .o_wr_data    (o_wr_data)
  );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Reset leaves on a falling edge, clear of the sampling edge
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

// ==== testbench/tb_lsu_pipe.sv ====
`timescale 1ns/1ns

module tb_lsu_pipe
  import lsu_pkg::*;
();

  localparam int XLEN_W       = 64;
  localparam int LINE_B       = 16;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 2;
  localparam int CHECK_DELAY  = CLK_PERIOD / 4;   // After the drive, before the next rise
  localparam int ISSUE_CYCLES = 500;
  localparam int REPLAY_CYCLES = 500;
  localparam int DENSE_CYCLES = 1000;
  localparam int TEST_CYCLES  = ISSUE_CYCLES + REPLAY_CYCLES + DENSE_CYCLES;
  localparam int WATCHDOG_NS  = (TEST_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;

  logic              clk;
  logic              reset_n;
  logic              rs_valid;
  inst_u             rs_inst;
  logic [RNID_W-1:0] rs_rnid;
  logic [63:0]       rs_rs1;
  logic [63:0]       rs_rs2;
  logic              rp_valid;
  inst_u             rp_inst;
  logic [RNID_W-1:0] rp_rnid;
  logic [63:0]       rp_rs1;
  logic [63:0]       rp_rs2;
  logic              rs_conflicted;
  logic              l1d_rd_valid;
  logic [63:0]       l1d_rd_paddr;
  logic              l1d_hit;
  logic [127:0]      l1d_line;
  logic [7:0]        fwd_dw;
  logic [63:0]       fwd_data;
  logic              st_valid;
  logic [63:0]       st_paddr;
  logic [63:0]       st_data;
  size_t             st_size;
  logic              ex2_miss;
  logic              wr_valid;
  logic [RNID_W-1:0] wr_rnid;
  logic [63:0]       wr_data;

  integer            seed;
  int                n_checks;
  int                n_errors;
  logic [127:0]      line_mem [logic [59:0]];  // Sparse, filled on first touch

  // ------------------------------
  // Model state, one set per stage
  // ------------------------------
  logic              m_rs_v;
  logic [31:0]       m_rs_inst;
  logic [RNID_W-1:0] m_rs_rnid;
  logic [63:0]       m_rs_a;
  logic [63:0]       m_rs_b;
  logic              m_e1_v;
  logic [31:0]       m_e1_inst;
  logic [RNID_W-1:0] m_e1_rnid;
  logic [63:0]       m_e1_a;
  logic [63:0]       m_e1_b;
  logic              m_e2_v;
  logic [63:0]       m_e2_addr;
  logic [2:0]        m_e2_f3;
  logic [4:0]        m_e2_rd;
  logic [RNID_W-1:0] m_e2_rnid;
  logic              m_e3_v;
  logic [RNID_W-1:0] m_e3_rnid;
  logic [63:0]       m_e3_data;
  logic              x2_miss;
  logic [63:0]       x2_data;

  tb_clock #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  lsu_pipe #(
    .XLEN_W (XLEN_W),
    .LINE_B (LINE_B)
  ) i_dut (
    .i_clk               (clk),
    .i_reset_n           (reset_n),
    .i_rs_valid          (rs_valid),
    .i_rs_inst           (rs_inst),
    .i_rs_rnid           (rs_rnid),
    .i_rs_rs1_data       (rs_rs1),
    .i_rs_rs2_data       (rs_rs2),
    .i_rp_valid          (rp_valid),
    .i_rp_inst           (rp_inst),
    .i_rp_rnid           (rp_rnid),
    .i_rp_rs1_data       (rp_rs1),
    .i_rp_rs2_data       (rp_rs2),
    .o_ex0_rs_conflicted (rs_conflicted),
    .o_l1d_rd_valid      (l1d_rd_valid),
    .o_l1d_rd_paddr      (l1d_rd_paddr),
    .i_l1d_hit           (l1d_hit),
    .i_l1d_line          (l1d_line),
    .i_fwd_dw            (fwd_dw),
    .i_fwd_data          (fwd_data),
    .o_st_valid          (st_valid),
    .o_st_paddr          (st_paddr),
    .o_st_data           (st_data),
    .o_st_size           (st_size),
    .o_ex2_miss          (ex2_miss),
    .o_wr_valid          (wr_valid),
    .o_wr_rnid           (wr_rnid),
    .o_wr_data           (wr_data)
  );

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic logic [63:0] rand64();
    return {next_rand(), next_rand()};
  endfunction

  // Mostly loads and stores, some other opcodes, x0 targets now and then
  function automatic logic [31:0] make_inst();
    logic [31:0] w;
    logic [31:0] pick;
    w    = next_rand();
    pick = next_rand();
    if (pick[2:0] < 3'd3)
      w[6:0] = OPC_LOAD;
    else if (pick[2:0] < 3'd6)
      w[6:0] = OPC_STORE;
    if (pick[5:3] == 3'd0)
      w[11:7] = 5'd0;
    return w;
  endfunction

  // Small base addresses so lines get reused
  function automatic logic [63:0] make_rs1();
    logic [31:0] r;
    r = next_rand();
    if (r[1:0] == 2'd0)
      return rand64();
    return {52'd0, r[19:8]};
  endfunction

  function automatic logic [63:0] eff_addr(input logic [31:0] inst, input logic [63:0] rs1);
    logic [11:0] imm;
    if (inst[6:0] == OPC_STORE)
      imm = {inst[31:25], inst[11:7]};  // S-type split immediate
    else
      imm = inst[31:20];
    return rs1 + {{52{imm[11]}}, imm};
  endfunction

  function automatic logic [127:0] line_at(input logic [63:0] addr);
    if (!line_mem.exists(addr[63:4]))
      line_mem[addr[63:4]] = {rand64(), rand64()};
    return line_mem[addr[63:4]];
  endfunction

  task automatic check_value(input string sig, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("FAIL t=%0t %s: got %h, expected %h", $time, sig, got, exp);
      n_errors++;
    end
  endtask

  task automatic drive_issue(input int rs_pct, input int rp_pct);
    logic [31:0] r;
    r        = next_rand();
    rs_valid = (r % 100) < rs_pct;
    rs_inst  = make_inst();
    r        = next_rand();
    rs_rnid  = r[RNID_W-1:0];
    rs_rs1   = make_rs1();
    rs_rs2   = rand64();
    r        = next_rand();
    rp_valid = (r % 100) < rp_pct;
    rp_inst  = make_inst();
    r        = next_rand();
    rp_rnid  = r[RNID_W-1:0];
    rp_rs1   = make_rs1();
    rp_rs2   = rand64();
  endtask

  // Answer for the load sitting in EX2
  task automatic drive_cache();
    logic [31:0] r;
    r        = next_rand();
    l1d_line = m_e2_v ? line_at(m_e2_addr) : {rand64(), rand64()};
    l1d_hit  = r[0];
    case (r[3:2])
      2'd0:    fwd_dw = 8'hff;
      2'd1:    fwd_dw = 8'h00;
      default: fwd_dw = r[15:8];
    endcase
    fwd_data = rand64();
  endtask

  // Misaligned offsets round down to the access size
  task automatic model_load();
    int          nbytes;
    int          ofs;
    int          dw;
    int          p;
    logic [63:0] val;
    logic        covered;
    nbytes  = 1 << m_e2_f3[1:0];
    ofs     = int'(m_e2_addr[2:0]) & ~(nbytes - 1);
    dw      = int'(m_e2_addr[3]);
    val     = 64'd0;
    covered = 1'b1;
    for (int i = 0; i < nbytes; i++) begin
      p = ofs + i;
      if (fwd_dw[p]) begin
        val[i*8 +: 8] = fwd_data[p*8 +: 8];
      end else begin
        val[i*8 +: 8] = l1d_line[dw*64 + p*8 +: 8];
        covered = 1'b0;
      end
    end
    if (!m_e2_f3[2] && nbytes < 8 && val[nbytes*8-1])
      val = val | (~64'd0 << (nbytes * 8));  // LB, LH, LW sign fill
    x2_miss = m_e2_v && !l1d_hit && !covered;
    x2_data = val;
  endtask

  task automatic check_window();
    logic        is_ld;
    logic        is_st;
    logic [63:0] ea;
    is_ld = m_e1_v && m_e1_inst[6:0] == OPC_LOAD;
    is_st = m_e1_v && m_e1_inst[6:0] == OPC_STORE;
    ea    = eff_addr(m_e1_inst, m_e1_a);
    check_value("o_ex0_rs_conflicted", 64'(rs_conflicted), 64'(rp_valid & m_rs_v));
    check_value("o_l1d_rd_valid", 64'(l1d_rd_valid), 64'(is_ld));
    if (is_ld)
      check_value("o_l1d_rd_paddr", l1d_rd_paddr, {ea[63:4], 4'b0000});
    check_value("o_st_valid", 64'(st_valid), 64'(is_st));
    if (is_st) begin
      check_value("o_st_paddr", st_paddr, ea);
      check_value("o_st_data", st_data, m_e1_b);
      check_value("o_st_size", 64'(st_size), 64'(m_e1_inst[13:12]));
    end
    model_load();
    check_value("o_ex2_miss", 64'(ex2_miss), 64'(x2_miss));
    check_value("o_wr_valid", 64'(wr_valid), 64'(m_e3_v));
    if (m_e3_v) begin
      check_value("o_wr_rnid", 64'(wr_rnid), 64'(m_e3_rnid));
      check_value("o_wr_data", wr_data, m_e3_data);
    end
  endtask

  // What the next rising edge does to every stage
  task automatic advance_model();
    m_e3_v    = m_e2_v && !x2_miss && m_e2_rd != 5'd0;
    m_e3_rnid = m_e2_rnid;
    m_e3_data = x2_data;
    m_e2_v    = m_e1_v && m_e1_inst[6:0] == OPC_LOAD;
    m_e2_addr = eff_addr(m_e1_inst, m_e1_a);
    m_e2_f3   = m_e1_inst[14:12];
    m_e2_rd   = m_e1_inst[11:7];
    m_e2_rnid = m_e1_rnid;
    if (rp_valid) begin
      m_e1_v    = 1'b1;
      m_e1_inst = rp_inst;
      m_e1_rnid = rp_rnid;
      m_e1_a    = rp_rs1;
      m_e1_b    = rp_rs2;
    end else begin
      m_e1_v    = m_rs_v;
      m_e1_inst = m_rs_inst;
      m_e1_rnid = m_rs_rnid;
      m_e1_a    = m_rs_a;
      m_e1_b    = m_rs_b;
    end
    m_rs_v    = rs_valid;
    m_rs_inst = rs_inst;
    m_rs_rnid = rs_rnid;
    m_rs_a    = rs_rs1;
    m_rs_b    = rs_rs2;
  endtask

  task automatic check_reset_state();
    int errs0;
    errs0 = n_errors;
    wait (reset_n);
    #(CHECK_DELAY);
    check_value("o_ex0_rs_conflicted", 64'(rs_conflicted), 64'd0);
    check_value("o_l1d_rd_valid", 64'(l1d_rd_valid), 64'd0);
    check_value("o_st_valid", 64'(st_valid), 64'd0);
    check_value("o_ex2_miss", 64'(ex2_miss), 64'd0);
    check_value("o_wr_valid", 64'(wr_valid), 64'd0);
    $display("test reset_state: %0d errors", n_errors - errs0);
  endtask

  task automatic run_test(input string name, input int cycles, input int rs_pct,
                          input int rp_pct);
    int errs0;
    int chk0;
    errs0 = n_errors;
    chk0  = n_checks;
    repeat (cycles) begin
      @(negedge clk);
      drive_issue(rs_pct, rp_pct);
      drive_cache();
      #(CHECK_DELAY);
      check_window();
      advance_model();
    end
    $display("test %s: %0d checks, %0d errors", name, n_checks - chk0, n_errors - errs0);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    seed      = 32'h22ca;
    n_checks  = 0;
    n_errors  = 0;
    rs_valid  = 1'b0;
    rs_inst   = '0;
    rs_rnid   = '0;
    rs_rs1    = '0;
    rs_rs2    = '0;
    rp_valid  = 1'b0;
    rp_inst   = '0;
    rp_rnid   = '0;
    rp_rs1    = '0;
    rp_rs2    = '0;
    l1d_hit   = 1'b0;
    l1d_line  = '0;
    fwd_dw    = '0;
    fwd_data  = '0;
    m_rs_v    = 1'b0;
    m_rs_inst = '0;
    m_rs_rnid = '0;
    m_rs_a    = '0;
    m_rs_b    = '0;
    m_e1_v    = 1'b0;
    m_e1_inst = '0;
    m_e1_rnid = '0;
    m_e1_a    = '0;
    m_e1_b    = '0;
    m_e2_v    = 1'b0;
    m_e2_addr = '0;
    m_e2_f3   = '0;
    m_e2_rd   = '0;
    m_e2_rnid = '0;
    m_e3_v    = 1'b0;
    m_e3_rnid = '0;
    m_e3_data = '0;
    x2_miss   = 1'b0;
    x2_data   = '0;

    check_reset_state();
    run_test("issue_only", ISSUE_CYCLES, 70, 0);
    run_test("replay_mix", REPLAY_CYCLES, 60, 40);
    run_test("dense", DENSE_CYCLES, 90, 30);

    $display("total: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== build.f ====
hdl/lsu_pkg.sv
hdl/lsu_issue_select.sv
hdl/lsu_addr_gen.sv
hdl/lsu_load_align.sv
hdl/lsu_writeback.sv
hdl/lsu_pipe.sv
testbench/tb_clock.sv
testbench/tb_lsu_pipe.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_lsu_pipe_sim

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module tb_lsu_pipe -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi
